// ==== Bender.yml ====
package:
  name: rx_core

sources:
  - hw/rx_pkg.sv
  - hw/sample_fifo.sv
  - hw/rx_bus_slave.sv
  - hw/rx_frontend.sv
  - hw/rx_decim.sv
  - hw/rx_top.sv
  - target: test
    files:
      - testbench/rx_asserts.sv
      - testbench/tb_rx.sv

// ==== hw/rx_bus_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_bus_slave
(
   input  wire                                   clk,
   input  wire                                   rst,
   input  wire                                   i_wb_cyc,
   input  wire                                   i_wb_stb,
   input  wire                                   i_wb_we,
   input  wire        [2:0]                      i_wb_adr,
   input  wire        [31:0]                     i_wb_dat,
   output logic       [31:0]                     o_wb_dat,
   output logic                                  o_wb_ack,
   input  rx_pkg::iq_word_u                      i_fifo_head,
   input  wire        [rx_pkg::LVL_W-1:0]        i_fifo_level,
   input  wire                                   i_fifo_overflow,
   output logic                                  o_run,
   output logic       [1:0]                      o_sel_i,
   output logic       [1:0]                      o_sel_q,
   output logic       [7:0]                      o_rate,
   output rx_pkg::iq_word_u                      o_scale,
   output logic signed [rx_pkg::ADC_W-1:0]       o_ofs_a,
   output logic signed [rx_pkg::ADC_W-1:0]       o_ofs_b,
   output logic                                  o_fifo_pop,
   output logic                                  o_ovf_clear
);

   logic        wb_req;     // new transfer, ack goes high on the next edge
   logic [31:0] ctrl_r;
   logic [31:0] rd_data;
   logic        fifo_empty;

   assign wb_req     = i_wb_cyc & i_wb_stb & ~o_wb_ack;
   assign fifo_empty = (i_fifo_level == '0);

   // pulses act on the edge that raises ack
   assign o_fifo_pop  = wb_req & ~i_wb_we & (i_wb_adr == rx_pkg::ADDR_DATA) & ~fifo_empty;
   assign o_ovf_clear = wb_req & i_wb_we & (i_wb_adr == rx_pkg::ADDR_STATUS) & i_wb_dat[8];

   // ctrl fields
   assign o_run   = ctrl_r[0];
   assign o_sel_i = ctrl_r[2:1];
   assign o_sel_q = ctrl_r[4:3];
   assign o_rate  = ctrl_r[15:8];

   always_ff @(posedge clk)
   begin
      if (rst)
         o_wb_ack <= 1'b0;
      else
         o_wb_ack <= wb_req;   // single-cycle ack
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ctrl_r      <= '0;
         o_scale.raw <= '0;
         o_ofs_a     <= '0;
         o_ofs_b     <= '0;
      end
      else if (wb_req && i_wb_we)
      begin
         case (i_wb_adr)
            rx_pkg::ADDR_CTRL:  ctrl_r      <= i_wb_dat;
            rx_pkg::ADDR_SCALE: o_scale.raw <= i_wb_dat;
            rx_pkg::ADDR_OFS_A: o_ofs_a     <= i_wb_dat[rx_pkg::ADC_W-1:0];
            rx_pkg::ADDR_OFS_B: o_ofs_b     <= i_wb_dat[rx_pkg::ADC_W-1:0];
            default: ;          // status and data are not writable
         endcase
      end
   end

   always_comb
   begin
      case (i_wb_adr)
         rx_pkg::ADDR_CTRL:   rd_data = ctrl_r;
         rx_pkg::ADDR_SCALE:  rd_data = o_scale.raw;
         rx_pkg::ADDR_OFS_A:  rd_data = {{(32-rx_pkg::ADC_W){o_ofs_a[rx_pkg::ADC_W-1]}}, o_ofs_a};
         rx_pkg::ADDR_OFS_B:  rd_data = {{(32-rx_pkg::ADC_W){o_ofs_b[rx_pkg::ADC_W-1]}}, o_ofs_b};
         rx_pkg::ADDR_STATUS: rd_data = {23'd0, i_fifo_overflow, 3'd0, i_fifo_level};
         rx_pkg::ADDR_DATA:   rd_data = fifo_empty ? 32'd0 : i_fifo_head.raw;
         default:             rd_data = 32'd0;
      endcase
   end

   // captured with the pop so the head is taken before it advances
   always_ff @(posedge clk)
   begin
      if (wb_req && !i_wb_we)
         o_wb_dat <= rd_data;
   end

endmodule

`default_nettype wire

// ==== hw/rx_decim.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_decim
(
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               i_run,
   input  wire        [7:0]                  i_rate,
   input  wire                               i_valid,
   input  wire signed [rx_pkg::OUT_W-1:0]    i_i,
   input  wire signed [rx_pkg::OUT_W-1:0]    i_q,
   output logic                              o_valid,
   output rx_pkg::iq_word_u                  o_word
);

   logic signed [rx_pkg::ACC_W-1:0]  acc_i, acc_q;
   logic signed [rx_pkg::ACC_W-1:0]  sum_i, sum_q;
   logic        [7:0]                cnt;
   logic        [7:0]                rate_eff;
   logic                             last;      // this input closes the group

   // clamp an accumulator value into OUT_W bits
   function automatic logic signed [rx_pkg::OUT_W-1:0] sat(
      input logic signed [rx_pkg::ACC_W-1:0] v);
      logic [rx_pkg::ACC_W-rx_pkg::OUT_W:0] top;
      top = v[rx_pkg::ACC_W-1:rx_pkg::OUT_W-1];
      if (top == {(rx_pkg::ACC_W-rx_pkg::OUT_W+1){v[rx_pkg::ACC_W-1]}})
         return v[rx_pkg::OUT_W-1:0];
      else if (v[rx_pkg::ACC_W-1])
         return {1'b1, {(rx_pkg::OUT_W-1){1'b0}}};   // -32768
      else
         return {1'b0, {(rx_pkg::OUT_W-1){1'b1}}};   // +32767
   endfunction

   assign rate_eff = (i_rate == 8'd0) ? 8'd1 : i_rate;
   assign sum_i    = acc_i + i_i;
   assign sum_q    = acc_q + i_q;
   assign last     = (cnt == rate_eff - 8'd1);

   always_ff @(posedge clk)
   begin
      if (rst || !i_run)
      begin
         acc_i   <= '0;
         acc_q   <= '0;
         cnt     <= '0;
         o_valid <= 1'b0;
      end
      else
      begin
         o_valid <= i_valid & last;
         if (i_valid)
         begin
            if (last)
            begin
               acc_i <= '0;       // dump
               acc_q <= '0;
               cnt   <= '0;
            end
            else
            begin
               acc_i <= sum_i;
               acc_q <= sum_q;
               cnt   <= cnt + 8'd1;
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_valid && last)
      begin
         o_word.iq.i <= sat(sum_i);
         o_word.iq.q <= sat(sum_q);
      end
   end

endmodule

`default_nettype wire

// ==== hw/rx_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_frontend
(
   input  wire                               clk,
   input  wire                               rst,
   input  wire signed [rx_pkg::ADC_W-1:0]    i_adc_a,
   input  wire signed [rx_pkg::ADC_W-1:0]    i_adc_b,
   input  wire                               i_adc_valid,
   input  wire                               i_run,
   input  wire        [1:0]                  i_sel_i,
   input  wire        [1:0]                  i_sel_q,
   input  wire signed [rx_pkg::ADC_W-1:0]    i_ofs_a,
   input  wire signed [rx_pkg::ADC_W-1:0]    i_ofs_b,
   input  rx_pkg::iq_word_u                  i_scale,
   output logic                              o_valid,
   output logic signed [rx_pkg::OUT_W-1:0]   o_i,
   output logic signed [rx_pkg::OUT_W-1:0]   o_q
);

   logic signed [rx_pkg::OFS_W-1:0]   a_ofs, b_ofs;
   logic signed [rx_pkg::OFS_W-1:0]   mux_i, mux_q;
   logic signed [rx_pkg::OFS_W-1:0]   d_i, d_q;       // stage 1
   logic signed [2*rx_pkg::OFS_W:0]   prod_i, prod_q;  // 31 bits
   logic                              v1;

   // 15 bits so the difference never wraps
   assign a_ofs = $signed({i_adc_a[rx_pkg::ADC_W-1], i_adc_a})
                - $signed({i_ofs_a[rx_pkg::ADC_W-1], i_ofs_a});
   assign b_ofs = $signed({i_adc_b[rx_pkg::ADC_W-1], i_adc_b})
                - $signed({i_ofs_b[rx_pkg::ADC_W-1], i_ofs_b});

   always_comb
   begin
      case (i_sel_i)
         rx_pkg::SEL_A:    mux_i = a_ofs;
         rx_pkg::SEL_B:    mux_i = b_ofs;
         rx_pkg::SEL_ZERO: mux_i = '0;
         default:          mux_i = '0;
      endcase
      case (i_sel_q)
         rx_pkg::SEL_A:    mux_q = a_ofs;
         rx_pkg::SEL_B:    mux_q = b_ofs;
         rx_pkg::SEL_ZERO: mux_q = '0;
         default:          mux_q = '0;
      endcase
   end

   // Q1.15 gain
   assign prod_i = d_i * i_scale.iq.i;
   assign prod_q = d_q * i_scale.iq.q;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         v1      <= 1'b0;
         o_valid <= 1'b0;
      end
      else
      begin
         v1      <= i_adc_valid & i_run;
         o_valid <= v1;
      end
   end

   always_ff @(posedge clk)
   begin
      d_i <= mux_i;
      d_q <= mux_q;
      o_i <= prod_i[30:15];   // >>> 15, floors toward minus infinity
      o_q <= prod_q[30:15];
   end

endmodule

`default_nettype wire

// ==== hw/rx_pkg.sv ====
`default_nettype none

package rx_pkg;

   // datapath widths
   localparam int ADC_W      = 14;
   localparam int OFS_W      = 15;  // adc minus offset, one extra bit
   localparam int OUT_W      = 16;
   localparam int ACC_W      = 24;  // holds 255 full-scale samples

   // sample buffer
   localparam int FIFO_DEPTH = 16;
   localparam int LVL_W      = 5;   // 0..16 inclusive

   // word addresses on the 3-bit bus address
   localparam logic [2:0] ADDR_CTRL   = 3'd0;
   localparam logic [2:0] ADDR_SCALE  = 3'd1;
   localparam logic [2:0] ADDR_OFS_A  = 3'd2;
   localparam logic [2:0] ADDR_OFS_B  = 3'd3;
   localparam logic [2:0] ADDR_STATUS = 3'd4;
   localparam logic [2:0] ADDR_DATA   = 3'd5;

   // channel select codes, 3 behaves like SEL_ZERO
   localparam logic [1:0] SEL_A    = 2'd0;
   localparam logic [1:0] SEL_B    = 2'd1;
   localparam logic [1:0] SEL_ZERO = 2'd2;

   // I in the upper half, Q in the lower half
   typedef struct packed {
      logic signed [15:0] i;
      logic signed [15:0] q;
   } iq_pair_t;

   typedef union packed {
      logic [31:0] raw;
      iq_pair_t    iq;
   } iq_word_u;

endpackage

`default_nettype wire

// ==== hw/rx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_top
(
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               i_wb_cyc,
   input  wire                               i_wb_stb,
   input  wire                               i_wb_we,
   input  wire        [2:0]                  i_wb_adr,
   input  wire        [31:0]                 i_wb_dat,
   output logic       [31:0]                 o_wb_dat,
   output logic                              o_wb_ack,
   input  wire signed [rx_pkg::ADC_W-1:0]    i_adc_a,
   input  wire signed [rx_pkg::ADC_W-1:0]    i_adc_b,
   input  wire                               i_adc_valid
);

   // settings from the bus slave
   logic                              run;
   logic        [1:0]                 sel_i, sel_q;
   logic        [7:0]                 rate;
   rx_pkg::iq_word_u                  scale;
   logic signed [rx_pkg::ADC_W-1:0]   ofs_a, ofs_b;

   logic                              fe_valid;
   logic signed [rx_pkg::OUT_W-1:0]   fe_i, fe_q;
   logic                              dec_valid;
   rx_pkg::iq_word_u                  dec_word;

   // buffer side
   logic                              fifo_pop, ovf_clear;
   rx_pkg::iq_word_u                  fifo_head;
   logic        [rx_pkg::LVL_W-1:0]   fifo_level;
   logic                              fifo_overflow;

   rx_bus_slave rx_bus_slave_i (
      .clk(clk), .rst(rst),
      .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
      .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
      .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
      .i_fifo_head(fifo_head), .i_fifo_level(fifo_level),
      .i_fifo_overflow(fifo_overflow),
      .o_run(run), .o_sel_i(sel_i), .o_sel_q(sel_q), .o_rate(rate),
      .o_scale(scale), .o_ofs_a(ofs_a), .o_ofs_b(ofs_b),
      .o_fifo_pop(fifo_pop), .o_ovf_clear(ovf_clear)
   );

   rx_frontend rx_frontend_i (
      .clk(clk), .rst(rst),
      .i_adc_a(i_adc_a), .i_adc_b(i_adc_b), .i_adc_valid(i_adc_valid),
      .i_run(run), .i_sel_i(sel_i), .i_sel_q(sel_q),
      .i_ofs_a(ofs_a), .i_ofs_b(ofs_b), .i_scale(scale),
      .o_valid(fe_valid), .o_i(fe_i), .o_q(fe_q)
   );

   rx_decim rx_decim_i (
      .clk(clk), .rst(rst), .i_run(run), .i_rate(rate),
      .i_valid(fe_valid), .i_i(fe_i), .i_q(fe_q),
      .o_valid(dec_valid), .o_word(dec_word)
   );

   sample_fifo sample_fifo_i (
      .clk(clk), .rst(rst),
      .i_push(dec_valid), .i_data(dec_word),
      .i_pop(fifo_pop), .i_ovf_clear(ovf_clear),
      .o_head(fifo_head), .o_level(fifo_level), .o_overflow(fifo_overflow)
   );

endmodule

`default_nettype wire

// ==== hw/sample_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module sample_fifo
(
   input  wire                         clk,
   input  wire                         rst,
   input  wire                         i_push,
   input  rx_pkg::iq_word_u            i_data,
   input  wire                         i_pop,
   input  wire                         i_ovf_clear,
   output rx_pkg::iq_word_u            o_head,
   output logic [rx_pkg::LVL_W-1:0]    o_level,
   output logic                        o_overflow
);

   rx_pkg::iq_word_u                            mem [rx_pkg::FIFO_DEPTH];
   logic [$clog2(rx_pkg::FIFO_DEPTH)-1:0]       wr_ptr, rd_ptr;
   logic                                        full, empty;
   logic                                        do_push, do_pop;

   assign full    = (o_level == rx_pkg::FIFO_DEPTH);
   assign empty   = (o_level == '0);
   assign do_push = i_push & ~full;   // dropped when full
   assign do_pop  = i_pop & ~empty;

   assign o_head = mem[rd_ptr];   // fall-through head

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= i_data;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         o_level    <= '0;
         o_overflow <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;

         case ({do_push, do_pop})
            2'b10:   o_level <= o_level + 1'b1;
            2'b01:   o_level <= o_level - 1'b1;
            default: ;   // both or neither
         endcase

         // clear wins over a set in the same cycle
         if (i_ovf_clear)
            o_overflow <= 1'b0;
         else if (i_push && full)
            o_overflow <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== list.f ====
hw/rx_pkg.sv
hw/sample_fifo.sv
hw/rx_bus_slave.sv
hw/rx_frontend.sv
hw/rx_decim.sv
hw/rx_top.sv
testbench/rx_asserts.sv
testbench/tb_rx.sv

// ==== testbench/rx_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_asserts
(
   input wire                        clk,
   input wire                        rst,
   input wire                        i_wb_cyc,
   input wire                        i_wb_stb,
   input wire                        i_wb_ack,
   input wire [rx_pkg::LVL_W-1:0]    i_level,
   input wire                        i_push,
   input wire                        i_pop
);

   int fail_count;   // number of failed assertions

   ack_single: assert property (@(posedge clk) disable iff (rst) i_wb_ack |=> !i_wb_ack)
      else
      begin
         $error("wishbone ack high for two cycles");
         fail_count++;
      end

   ack_after_req: assert property (@(posedge clk) disable iff (rst)
                                   $rose(i_wb_ack) |-> $past(i_wb_cyc && i_wb_stb))
      else
      begin
         $error("wishbone ack without cyc and stb");
         fail_count++;
      end

   level_max: assert property (@(posedge clk) disable iff (rst)
                               i_level <= rx_pkg::FIFO_DEPTH)
      else
      begin
         $error("FIFO level above depth");
         fail_count++;
      end

   // level only moves on a push or a pop
   level_hold: assert property (@(posedge clk) disable iff (rst)
                                (!i_push && !i_pop) |=> $stable(i_level))
      else
      begin
         $error("FIFO level changed with no push or pop");
         fail_count++;
      end

endmodule

bind rx_top rx_asserts rx_asserts_i (
   .clk(clk), .rst(rst),
   .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_ack(o_wb_ack),
   .i_level(fifo_level), .i_push(dec_valid), .i_pop(fifo_pop)
);

`default_nettype wire

// ==== testbench/tb_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rx;

   localparam int CLK_HALF   = 20;      // 40 ns period
   localparam int MAX_CYCLES = 20000;   // all tests together take under 2000 cycles
   localparam int ACK_LIMIT  = 16;      // cycles allowed per bus transfer
   localparam int POLL_LIMIT = 64;      // status reads before giving up

   logic                              clk = 1'b0;
   logic                              rst;
   logic                              i_wb_cyc, i_wb_stb, i_wb_we;
   logic        [2:0]                 i_wb_adr;
   logic        [31:0]                i_wb_dat;
   logic        [31:0]                o_wb_dat;
   logic                              o_wb_ack;
   logic signed [rx_pkg::ADC_W-1:0]   i_adc_a, i_adc_b;
   logic                              i_adc_valid;

   int          cycles;
   int          errors;
   int          tests_ok;
   int          tests_bad;
   logic [31:0] lcg_state;

   // reference model state
   int                m_ofs_a, m_ofs_b, m_gain_i, m_gain_q, m_rate;
   logic [1:0]        m_sel_i, m_sel_q;
   int                m_acc_i, m_acc_q, m_cnt;
   rx_pkg::iq_word_u  exp_q[$];

   rx_top rx_top_i (
      .clk(clk), .rst(rst),
      .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
      .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
      .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
      .i_adc_a(i_adc_a), .i_adc_b(i_adc_b), .i_adc_valid(i_adc_valid)
   );

   always #(CLK_HALF) clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   function logic signed [rx_pkg::ADC_W-1:0] rand_adc();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[29:16];   // upper bits are the better ones
   endfunction

   function automatic logic [31:0] ctrl_word(input logic run, input logic [1:0] sel_i,
                                             input logic [1:0] sel_q, input int rate);
      return {16'd0, 8'(rate), 3'd0, sel_q, sel_i, run};
   endfunction

   // floored channel value after offset, mux and Q1.15 gain
   function automatic int fe_model(input logic [1:0] sel, input int a, input int b,
                                   input int gain);
      longint d;
      longint p;
      case (sel)
         2'd0:    d = a - m_ofs_a;
         2'd1:    d = b - m_ofs_b;
         default: d = 0;   // codes 2 and 3
      endcase
      p = d * gain;
      if (p < 0 && (p % 32768) != 0)
         return int'(p / 32768) - 1;
      return int'(p / 32768);
   endfunction

   function automatic int clamp16(input int v);
      if (v > 32767)
         return 32767;
      if (v < -32768)
         return -32768;
      return v;
   endfunction

   task automatic model_step(input int a, input int b);
      rx_pkg::iq_word_u w;
      int               rate_eff;
      rate_eff = (m_rate == 0) ? 1 : m_rate;
      m_acc_i += fe_model(m_sel_i, a, b, m_gain_i);
      m_acc_q += fe_model(m_sel_q, a, b, m_gain_q);
      m_cnt++;
      if (m_cnt == rate_eff)
      begin
         w.iq.i = 16'(clamp16(m_acc_i));
         w.iq.q = 16'(clamp16(m_acc_q));
         exp_q.push_back(w);
         m_acc_i = 0;
         m_acc_q = 0;
         m_cnt   = 0;
      end
   endtask

   task automatic model_clear();
      m_acc_i = 0;
      m_acc_q = 0;
      m_cnt   = 0;
   endtask

   task automatic compare_word(input string name, input rx_pkg::iq_word_u exp,
                               input rx_pkg::iq_word_u act);
      if (act !== exp)
      begin
         $display("Mismatch at %0t: %s expected I=%0d Q=%0d (%h) got I=%0d Q=%0d (%h)",
                  $time, name, exp.iq.i, exp.iq.q, exp.raw, act.iq.i, act.iq.q, act.raw);
         errors++;
      end
   endtask

   task automatic compare_reg(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp)
      begin
         $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic wb_cycle(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
      int waited;
      waited = 0;
      rdat   = 32'd0;
      @(posedge clk);
      i_wb_cyc <= 1'b1;
      i_wb_stb <= 1'b1;
      i_wb_we  <= we;
      i_wb_adr <= adr;
      i_wb_dat <= wdat;
      @(negedge clk);   // ack and read data are settled here
      while (!o_wb_ack && waited < ACK_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (o_wb_ack)
         rdat = o_wb_dat;
      else
      begin
         $display("error at %0t: no ack from the DUT for address %0d", $time, adr);
         errors++;
      end
      @(posedge clk);
      i_wb_cyc <= 1'b0;
      i_wb_stb <= 1'b0;
      i_wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
      logic [31:0] unused;
      wb_cycle(1'b1, adr, data, unused);
   endtask

   task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
      wb_cycle(1'b0, adr, 32'd0, data);
   endtask

   task automatic reg_check(input logic [2:0] adr, input string name, input logic [31:0] exp);
      logic [31:0] d;
      wb_read(adr, d);
      compare_reg(name, exp, d);
   endtask

   // poll STATUS until it shows the level and overflow bit
   task automatic check_status(input int level, input logic ovf);
      logic [31:0] exp;
      logic [31:0] st;
      int          tries;
      exp   = (32'(ovf) << 8) | 32'(level);   // level in 4:0, overflow in bit 8
      tries = 0;
      wb_read(rx_pkg::ADDR_STATUS, st);
      while (st !== exp && tries < POLL_LIMIT)
      begin
         wb_read(rx_pkg::ADDR_STATUS, st);
         tries++;
      end
      compare_reg("STATUS", exp, st);
   endtask

   task automatic configure(input logic [1:0] sel_i, input logic [1:0] sel_q, input int rate,
                            input logic [31:0] scale, input int ofs_a, input int ofs_b);
      wb_write(rx_pkg::ADDR_CTRL, 32'd0);   // run low empties the decimator
      wb_write(rx_pkg::ADDR_SCALE, scale);
      wb_write(rx_pkg::ADDR_OFS_A, 32'(ofs_a));
      wb_write(rx_pkg::ADDR_OFS_B, 32'(ofs_b));
      wb_write(rx_pkg::ADDR_CTRL, ctrl_word(1'b1, sel_i, sel_q, rate));
      m_sel_i  = sel_i;
      m_sel_q  = sel_q;
      m_rate   = rate;
      m_gain_i = int'($signed(scale[31:16]));
      m_gain_q = int'($signed(scale[15:0]));
      m_ofs_a  = ofs_a;
      m_ofs_b  = ofs_b;
      model_clear();
   endtask

   task automatic drive_sample(input logic signed [rx_pkg::ADC_W-1:0] a,
                               input logic signed [rx_pkg::ADC_W-1:0] b);
      @(posedge clk);
      i_adc_a     <= a;
      i_adc_b     <= b;
      i_adc_valid <= 1'b1;
      model_step(a, b);
   endtask

   task automatic adc_idle();
      @(posedge clk);
      i_adc_valid <= 1'b0;
   endtask

   task automatic feed_random(input int n);
      for (int k = 0; k < n; k++)
         drive_sample(rand_adc(), rand_adc());
      adc_idle();
   endtask

   task automatic drain(input int n);
      logic [31:0]      d;
      rx_pkg::iq_word_u got;
      for (int k = 0; k < n; k++)
      begin
         wb_read(rx_pkg::ADDR_DATA, d);
         got.raw = d;
         if (exp_q.size() == 0)
         begin
            $display("error at %0t: DUT returned a sample the model did not expect", $time);
            errors++;
         end
         else
            compare_word("DATA", exp_q.pop_front(), got);
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (errors == errors_before)
      begin
         tests_ok++;
         $display("test %s: ok", name);
      end
      else
      begin
         tests_bad++;
         $display("test %s: %0d errors", name, errors - errors_before);
      end
   endtask

   task automatic test_registers();
      int e0;
      e0 = errors;
      reg_check(rx_pkg::ADDR_CTRL, "CTRL", 32'd0);
      reg_check(rx_pkg::ADDR_SCALE, "SCALE", 32'd0);
      reg_check(rx_pkg::ADDR_OFS_A, "OFS_A", 32'd0);
      reg_check(rx_pkg::ADDR_OFS_B, "OFS_B", 32'd0);
      reg_check(rx_pkg::ADDR_STATUS, "STATUS", 32'd0);
      wb_write(rx_pkg::ADDR_CTRL, 32'h0000_3A16);   // run stays low
      wb_write(rx_pkg::ADDR_SCALE, 32'h7FFF_8001);
      wb_write(rx_pkg::ADDR_OFS_A, 32'hFFFF_E000);  // -8192
      wb_write(rx_pkg::ADDR_OFS_B, 32'h0000_1FFF);
      reg_check(rx_pkg::ADDR_CTRL, "CTRL", 32'h0000_3A16);
      reg_check(rx_pkg::ADDR_SCALE, "SCALE", 32'h7FFF_8001);
      reg_check(rx_pkg::ADDR_OFS_A, "OFS_A", 32'hFFFF_E000);
      reg_check(rx_pkg::ADDR_OFS_B, "OFS_B", 32'h0000_1FFF);
      report_test("register reset and readback", e0);
   endtask

   task automatic test_mux_gain();
      int e0;
      e0 = errors;
      configure(rx_pkg::SEL_B, rx_pkg::SEL_A, 1, 32'h4000_C000, 100, -250);
      feed_random(8);
      check_status(8, 1'b0);
      drain(8);
      configure(rx_pkg::SEL_B, rx_pkg::SEL_ZERO, 1, 32'h6000_7000, -37, 412);
      feed_random(6);
      check_status(6, 1'b0);
      drain(6);
      report_test("mux, offset and gain", e0);
   endtask

   task automatic test_decimation();
      int e0;
      e0 = errors;
      configure(rx_pkg::SEL_A, rx_pkg::SEL_B, 4, 32'h5A00_3000, 10, -20);
      feed_random(12);
      check_status(3, 1'b0);
      drain(3);
      configure(rx_pkg::SEL_A, rx_pkg::SEL_B, 0, 32'h5A00_3000, 10, -20);  // acts as 1
      feed_random(5);
      check_status(5, 1'b0);
      drain(5);
      report_test("decimation rates 4 and 0", e0);
   endtask

   task automatic test_saturation();
      int               e0;
      logic [31:0]      d;
      rx_pkg::iq_word_u got;
      rx_pkg::iq_word_u lim;
      e0       = errors;
      lim.iq.i = 16'sh7FFF;
      lim.iq.q = 16'sh8000;
      configure(rx_pkg::SEL_A, rx_pkg::SEL_B, 200, 32'h7FFF_7FFF, 0, 0);
      for (int k = 0; k < 200; k++)
         drive_sample(14'sd8191, -14'sd8192);
      adc_idle();
      check_status(1, 1'b0);
      wb_read(rx_pkg::ADDR_DATA, d);
      got.raw = d;
      compare_word("DATA", lim, got);
      compare_word("DATA", exp_q.pop_front(), got);
      report_test("saturation at rate 200", e0);
   endtask

   task automatic test_overflow();
      int e0;
      e0 = errors;
      configure(rx_pkg::SEL_A, rx_pkg::SEL_B, 1, 32'h4000_4000, 0, 0);
      feed_random(20);
      check_status(16, 1'b1);
      drain(16);
      exp_q.delete();   // the last four were dropped
      reg_check(rx_pkg::ADDR_DATA, "DATA", 32'd0);
      check_status(0, 1'b1);
      wb_write(rx_pkg::ADDR_STATUS, 32'h0000_0100);
      reg_check(rx_pkg::ADDR_STATUS, "STATUS", 32'd0);
      report_test("FIFO overflow and drain", e0);
   endtask

   task automatic test_run_abort();
      int e0;
      e0 = errors;
      configure(rx_pkg::SEL_A, rx_pkg::SEL_B, 4, 32'h7000_5000, 5, -5);
      feed_random(3);
      wb_write(rx_pkg::ADDR_CTRL, ctrl_word(1'b0, rx_pkg::SEL_A, rx_pkg::SEL_B, 4));
      model_clear();   // partial group is lost
      wb_write(rx_pkg::ADDR_CTRL, ctrl_word(1'b1, rx_pkg::SEL_A, rx_pkg::SEL_B, 4));
      feed_random(4);
      check_status(1, 1'b0);
      drain(1);
      report_test("run cleared mid-group", e0);
   endtask

   initial
   begin
      lcg_state   = 32'd96;
      rst         = 1'b1;
      i_wb_cyc    = 1'b0;
      i_wb_stb    = 1'b0;
      i_wb_we     = 1'b0;
      i_wb_adr    = 3'd0;
      i_wb_dat    = 32'd0;
      i_adc_a     = '0;
      i_adc_b     = '0;
      i_adc_valid = 1'b0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      test_registers();
      test_mux_gain();
      test_decimation();
      test_saturation();
      test_overflow();
      test_run_abort();
      errors += rx_top_i.rx_asserts_i.fail_count;
      $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
               tests_ok, tests_bad, errors);
      if (errors == 0 && tests_bad == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire
